// File: hdl/park_admin_pkg.sv
package park_admin_pkg;

    // keypad and buttons
    localparam int KEY_COUNT = 16;
    localparam int BTN_MID   = 0;
    localparam int BTN_UP    = 1;

    typedef logic [3:0] key_idx_t;

    // login
    localparam int PASS_DIGITS = 5;
    localparam logic [4*PASS_DIGITS-1:0] ADMIN_PASSWORD = 20'h23568;
    localparam int LOGIN_TRIES = 4;

    typedef logic [2:0] fail_cnt_t;

    // key numbers used by the menu
    localparam key_idx_t KEY_MENU_SETUP     = 4'd2;
    localparam key_idx_t KEY_MENU_CLEAR     = 4'd5;
    localparam key_idx_t KEY_AREA_A         = 4'd10;
    localparam key_idx_t KEY_AREA_B         = 4'd11;
    localparam key_idx_t KEY_SETUP_PRICES   = 4'd11;
    localparam key_idx_t KEY_SETUP_OPEN     = 4'd14;
    localparam key_idx_t KEY_SETUP_DISCOUNT = 4'd13;
    localparam key_idx_t KEY_CONFIRM        = 4'd2;
    localparam key_idx_t KEY_CANCEL         = 4'd0;

    typedef struct packed {
        logic     valid;
        key_idx_t key;
    } key_event_t;

    typedef struct packed {
        logic mid;
        logic up;
    } button_event_t;

    typedef struct packed {
        key_event_t    key_ev;
        button_event_t btn_ev;
        logic          logged_in;
    } session_t;

    // order matters, edit runs step through it
    typedef enum logic [2:0] {
        start_a,
        start_b,
        each_a,
        each_b,
        open_a,
        open_b,
        discount
    } setting_field_t;

    typedef struct packed {
        logic           valid;
        setting_field_t field;
        logic [3:0]     value;
    } setting_write_t;

    typedef enum logic {
        area_a,
        area_b
    } park_area_t;

    typedef struct packed {
        logic       valid;
        park_area_t area;
    } clear_req_t;

    typedef enum logic [2:0] {
        main,
        setup,
        edit,
        area_pick,
        area_confirm
    } menu_state_t;

    typedef struct packed {
        logic [1:0] start_a;
        logic [1:0] start_b;
        logic [1:0] each_a;
        logic [1:0] each_b;
        logic [2:0] open_a;
        logic [2:0] open_b;
        logic [3:0] discount;
    } park_settings_t;

    localparam park_settings_t SETTINGS_DEFAULT = '{
        start_a:  2'd1,
        start_b:  2'd2,
        each_a:   2'd1,
        each_b:   2'd2,
        open_a:   3'd3,
        open_b:   3'd3,
        discount: 4'd8
    };

endpackage

// File: hdl/key_scan.sv
`timescale 1ns/1ps

module key_scan (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [park_admin_pkg::KEY_COUNT-1:0] keys,
    input  logic [1:0]                           buttons,
    output park_admin_pkg::key_event_t           key_ev,
    output park_admin_pkg::button_event_t        btn_ev
);

    logic [park_admin_pkg::KEY_COUNT-1:0] keys_q;
    logic [1:0]                           buttons_q;
    logic                                 single_key;
    logic                                 keys_idle;

    function automatic park_admin_pkg::key_idx_t key_index(
        input logic [park_admin_pkg::KEY_COUNT-1:0] k
    );
        park_admin_pkg::key_idx_t idx;
        idx = '0;
        for (int i = 0; i < park_admin_pkg::KEY_COUNT; i++) begin
            if (k[i]) begin
                idx = park_admin_pkg::key_idx_t'(i);
            end
        end
        return idx;
    endfunction

    // exactly one key held
    assign single_key = (keys != '0) && ((keys & (keys - 1'b1)) == '0);
    assign keys_idle  = (keys == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            keys_q    <= '0;
            buttons_q <= '0;
            key_ev    <= '0;
            btn_ev    <= '0;
        end else begin
            keys_q    <= keys;
            buttons_q <= buttons;

            // press only from a fully released keypad
            key_ev.valid <= single_key && (keys_q == '0);
            key_ev.key   <= key_index(keys);

            btn_ev.mid <= buttons[park_admin_pkg::BTN_MID] &&
                          !buttons_q[park_admin_pkg::BTN_MID] &&
                          !buttons[park_admin_pkg::BTN_UP] && keys_idle;
            btn_ev.up  <= buttons[park_admin_pkg::BTN_UP] &&
                          !buttons_q[park_admin_pkg::BTN_UP] &&
                          !buttons[park_admin_pkg::BTN_MID] && keys_idle;
        end
    end

endmodule

// File: hdl/login_check.sv
`timescale 1ns/1ps

module login_check (
    input  logic                          clk,
    input  logic                          rst,
    input  park_admin_pkg::key_event_t    key_ev,
    input  park_admin_pkg::button_event_t btn_ev,
    output park_admin_pkg::session_t      session,
    output park_admin_pkg::fail_cnt_t     fail_count,
    output logic                          locked
);

    localparam int CNT_W = $clog2(park_admin_pkg::PASS_DIGITS + 1);

    logic [4*park_admin_pkg::PASS_DIGITS-1:0] digits;
    logic [CNT_W-1:0]                         digit_cnt;
    logic                                     digits_full;
    logic                                     take_digit;
    logic                                     logged_in;
    park_admin_pkg::key_event_t               key_fwd;
    park_admin_pkg::button_event_t            btn_fwd;

    assign digits_full = (digit_cnt == CNT_W'(park_admin_pkg::PASS_DIGITS));

    // keys past the fifth wait for mid
    assign take_digit = !locked && !logged_in && key_ev.valid && !btn_ev.mid &&
                        !digits_full;

    always_ff @(posedge clk) begin
        if (take_digit) begin
            digits <= {digits[4*park_admin_pkg::PASS_DIGITS-5:0], key_ev.key};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            digit_cnt  <= '0;
            logged_in  <= 1'b0;
            fail_count <= '0;
            locked     <= 1'b0;
            key_fwd    <= '0;
            btn_fwd    <= '0;
        end else begin
            key_fwd <= '0;
            btn_fwd <= '0;

            if (!locked) begin
                if (logged_in) begin
                    key_fwd <= key_ev;
                    btn_fwd <= btn_ev;
                    if (btn_ev.up) begin
                        logged_in <= 1'b0;
                    end
                end else if (btn_ev.mid) begin
                    digit_cnt <= '0;
                    if (digits_full) begin
                        if (digits == park_admin_pkg::ADMIN_PASSWORD) begin
                            logged_in  <= 1'b1;
                            fail_count <= '0;
                        end else begin
                            fail_count <= fail_count + 1'b1;
                            if (fail_count ==
                                park_admin_pkg::fail_cnt_t'(park_admin_pkg::LOGIN_TRIES - 1)) begin
                                locked <= 1'b1;
                            end
                        end
                    end
                end else if (take_digit) begin
                    digit_cnt <= digit_cnt + 1'b1;
                end
            end
        end
    end

    // events reach the menu only inside a session
    assign session = '{
        key_ev:    key_fwd,
        btn_ev:    btn_fwd,
        logged_in: logged_in
    };

endmodule

// File: hdl/menu_control.sv
`timescale 1ns/1ps

module menu_control (
    input  logic                           clk,
    input  logic                           rst,
    input  park_admin_pkg::session_t       session,
    output park_admin_pkg::setting_write_t wr,
    output park_admin_pkg::clear_req_t     clr,
    output park_admin_pkg::menu_state_t    menu_state
);

    park_admin_pkg::menu_state_t    state;
    park_admin_pkg::setting_field_t field;
    park_admin_pkg::setting_field_t last_field;
    park_admin_pkg::park_area_t     area;
    logic                           pending_valid;
    logic [3:0]                     pending_value;
    logic                           armed;
    logic                           key_hit;
    logic                           key_ok;
    park_admin_pkg::key_idx_t       key;

    assign key_hit = session.key_ev.valid;
    assign key     = session.key_ev.key;

    // accepted keys per field, the key number is the value
    always_comb begin
        case (field)
            park_admin_pkg::start_a,
            park_admin_pkg::start_b,
            park_admin_pkg::open_a,
            park_admin_pkg::open_b:   key_ok = key inside {4'd0, 4'd2, 4'd3};
            park_admin_pkg::each_a,
            park_admin_pkg::each_b:   key_ok = key inside {4'd2, 4'd3};
            park_admin_pkg::discount: key_ok = key inside {[4'd5:4'd9]};
            default:                  key_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == park_admin_pkg::edit && key_hit && key_ok) begin
            pending_value <= key;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= park_admin_pkg::main;
            field         <= park_admin_pkg::start_a;
            last_field    <= park_admin_pkg::start_a;
            area          <= park_admin_pkg::area_a;
            pending_valid <= 1'b0;
            armed         <= 1'b0;
            wr            <= '0;
            clr           <= '0;
        end else begin
            wr.valid  <= 1'b0;
            clr.valid <= 1'b0;

            if (!session.logged_in) begin
                state         <= park_admin_pkg::main;
                pending_valid <= 1'b0;
                armed         <= 1'b0;
            end else begin
                case (state)
                    park_admin_pkg::main: begin
                        if (key_hit && key == park_admin_pkg::KEY_MENU_SETUP) begin
                            state <= park_admin_pkg::setup;
                        end else if (key_hit && key == park_admin_pkg::KEY_MENU_CLEAR) begin
                            state <= park_admin_pkg::area_pick;
                        end
                    end
                    park_admin_pkg::setup: begin
                        pending_valid <= 1'b0;
                        if (session.btn_ev.up) begin
                            state <= park_admin_pkg::main;
                        end else if (key_hit) begin
                            case (key)
                                park_admin_pkg::KEY_SETUP_PRICES: begin
                                    field      <= park_admin_pkg::start_a;
                                    last_field <= park_admin_pkg::each_b;
                                    state      <= park_admin_pkg::edit;
                                end
                                park_admin_pkg::KEY_SETUP_OPEN: begin
                                    field      <= park_admin_pkg::open_a;
                                    last_field <= park_admin_pkg::open_b;
                                    state      <= park_admin_pkg::edit;
                                end
                                park_admin_pkg::KEY_SETUP_DISCOUNT: begin
                                    field      <= park_admin_pkg::discount;
                                    last_field <= park_admin_pkg::discount;
                                    state      <= park_admin_pkg::edit;
                                end
                                default: ;
                            endcase
                        end
                    end
                    park_admin_pkg::edit: begin
                        if (session.btn_ev.mid && pending_valid) begin
                            wr.valid      <= 1'b1;
                            wr.field      <= field;
                            wr.value      <= pending_value;
                            pending_valid <= 1'b0;
                            if (field == last_field) begin
                                state <= park_admin_pkg::setup;
                            end else begin
                                field <= park_admin_pkg::setting_field_t'(field + 3'd1);
                            end
                        end else if (key_hit && key_ok) begin
                            pending_valid <= 1'b1;
                        end
                    end
                    park_admin_pkg::area_pick: begin
                        armed <= 1'b0;
                        if (session.btn_ev.up) begin
                            state <= park_admin_pkg::main;
                        end else if (key_hit && key == park_admin_pkg::KEY_AREA_A) begin
                            area  <= park_admin_pkg::area_a;
                            state <= park_admin_pkg::area_confirm;
                        end else if (key_hit && key == park_admin_pkg::KEY_AREA_B) begin
                            area  <= park_admin_pkg::area_b;
                            state <= park_admin_pkg::area_confirm;
                        end
                    end
                    park_admin_pkg::area_confirm: begin
                        if (session.btn_ev.mid && armed) begin
                            clr.valid <= 1'b1;
                            clr.area  <= area;
                            armed     <= 1'b0;
                            state     <= park_admin_pkg::main;
                        end else if (key_hit && key == park_admin_pkg::KEY_CONFIRM) begin
                            armed <= 1'b1;
                        end else if (key_hit && key == park_admin_pkg::KEY_CANCEL) begin
                            armed <= 1'b0;
                            state <= park_admin_pkg::main;
                        end
                    end
                    default: state <= park_admin_pkg::main;
                endcase
            end
        end
    end

    assign menu_state = state;

endmodule

// File: hdl/setting_store.sv
`timescale 1ns/1ps

module setting_store (
    input  logic                           clk,
    input  logic                           rst,
    input  park_admin_pkg::setting_write_t wr,
    input  park_admin_pkg::clear_req_t     clr,
    output park_admin_pkg::park_settings_t settings,
    output logic                           lot_clear_a,
    output logic                           lot_clear_b
);

    always_ff @(posedge clk) begin
        if (rst) begin
            settings <= park_admin_pkg::SETTINGS_DEFAULT;
        end else if (wr.valid) begin
            case (wr.field)
                park_admin_pkg::start_a: begin
                    settings.start_a <= wr.value[1:0];
                end
                park_admin_pkg::start_b: begin
                    settings.start_b <= wr.value[1:0];
                end
                park_admin_pkg::each_a: begin
                    settings.each_a <= wr.value[1:0];
                end
                park_admin_pkg::each_b: begin
                    settings.each_b <= wr.value[1:0];
                end
                park_admin_pkg::open_a: begin
                    settings.open_a <= wr.value[2:0];
                end
                park_admin_pkg::open_b: begin
                    settings.open_b <= wr.value[2:0];
                end
                park_admin_pkg::discount: begin
                    settings.discount <= wr.value;
                end
                default: ;
            endcase
        end
    end

    // one pulse per request, only the chosen area
    always_ff @(posedge clk) begin
        if (rst) begin
            lot_clear_a <= 1'b0;
            lot_clear_b <= 1'b0;
        end else begin
            lot_clear_a <= clr.valid && (clr.area == park_admin_pkg::area_a);
            lot_clear_b <= clr.valid && (clr.area == park_admin_pkg::area_b);
        end
    end

endmodule

// File: hdl/park_admin_top.sv
`timescale 1ns/1ps

module park_admin_top (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [park_admin_pkg::KEY_COUNT-1:0] keys,
    input  logic [1:0]                           buttons,
    output park_admin_pkg::park_settings_t       settings,
    output logic                                 logged_in,
    output park_admin_pkg::fail_cnt_t            fail_count,
    output logic                                 locked,
    output park_admin_pkg::menu_state_t          menu_state,
    output logic                                 lot_clear_a,
    output logic                                 lot_clear_b
);

    park_admin_pkg::key_event_t     key_ev;
    park_admin_pkg::button_event_t  btn_ev;
    park_admin_pkg::session_t       session;
    park_admin_pkg::setting_write_t wr;
    park_admin_pkg::clear_req_t     clr;

    key_scan u_key_scan (
        .clk     (clk),
        .rst     (rst),
        .keys    (keys),
        .buttons (buttons),
        .key_ev  (key_ev),
        .btn_ev  (btn_ev)
    );

    login_check u_login_check (
        .clk        (clk),
        .rst        (rst),
        .key_ev     (key_ev),
        .btn_ev     (btn_ev),
        .session    (session),
        .fail_count (fail_count),
        .locked     (locked)
    );

    menu_control u_menu_control (
        .clk        (clk),
        .rst        (rst),
        .session    (session),
        .wr         (wr),
        .clr        (clr),
        .menu_state (menu_state)
    );

    setting_store u_setting_store (
        .clk         (clk),
        .rst         (rst),
        .wr          (wr),
        .clr         (clr),
        .settings    (settings),
        .lot_clear_a (lot_clear_a),
        .lot_clear_b (lot_clear_b)
    );

    assign logged_in = session.logged_in;

endmodule

// File: tb/park_admin_checker.sv
`timescale 1ns/1ps

module park_admin_checker (
    input logic                        clk,
    input logic                        rst,
    input logic                        lot_clear_a,
    input logic                        lot_clear_b,
    input logic                        logged_in,
    input park_admin_pkg::fail_cnt_t   fail_count,
    input park_admin_pkg::menu_state_t menu_state
);

    clear_a_single: assert property (@(posedge clk) disable iff (rst)
        lot_clear_a |=> !lot_clear_a)
        else $error("lot_clear_a stays high for more than one cycle");

    clear_b_single: assert property (@(posedge clk) disable iff (rst)
        lot_clear_b |=> !lot_clear_b)
        else $error("lot_clear_b stays high for more than one cycle");

    fail_count_bound: assert property (@(posedge clk) disable iff (rst)
        fail_count <= park_admin_pkg::fail_cnt_t'(park_admin_pkg::LOGIN_TRIES))
        else $error("fail_count is above the lockout limit");

    // no menu outside a session, main one cycle after logout
    main_when_logged_out: assert property (@(posedge clk) disable iff (rst)
        !logged_in |=> menu_state == park_admin_pkg::main)
        else $error("menu_state is not main while logged out");

endmodule

bind park_admin_top park_admin_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .lot_clear_a (lot_clear_a),
    .lot_clear_b (lot_clear_b),
    .logged_in   (logged_in),
    .fail_count  (fail_count),
    .menu_state  (menu_state)
);

// File: tb/tb_park_admin.sv
`timescale 1ns/1ps

module tb_park_admin;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 10;
    localparam int POLL_LIMIT   = 50;
    localparam int MAX_OPS      = 256;

    localparam logic [3:0] OP_END       = 4'h0;
    localparam logic [3:0] OP_KEYS      = 4'h1;
    localparam logic [3:0] OP_MID       = 4'h2;
    localparam logic [3:0] OP_UP        = 4'h3;
    localparam logic [3:0] OP_FIELD     = 4'h4;
    localparam logic [3:0] OP_LOGGED_IN = 4'h5;
    localparam logic [3:0] OP_FAILS     = 4'h6;
    localparam logic [3:0] OP_LOCKED    = 4'h7;
    localparam logic [3:0] OP_CLEARS    = 4'h8;
    localparam logic [3:0] OP_RESET     = 4'h9;

    logic                           clk = 1'b0;
    logic                           rst = 1'b1;
    logic [15:0]                    keys = '0;
    logic [1:0]                     buttons = '0;
    park_admin_pkg::park_settings_t settings;
    logic                           logged_in;
    park_admin_pkg::fail_cnt_t      fail_count;
    logic                           locked;
    park_admin_pkg::menu_state_t    menu_state;
    logic                           lot_clear_a;
    logic                           lot_clear_b;

    logic [31:0] ops [MAX_OPS];
    int          mismatches = 0;
    int          other_errors = 0;
    int          clear_count_a = 0;
    int          clear_count_b = 0;

    park_admin_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .keys        (keys),
        .buttons     (buttons),
        .settings    (settings),
        .logged_in   (logged_in),
        .fail_count  (fail_count),
        .locked      (locked),
        .menu_state  (menu_state),
        .lot_clear_a (lot_clear_a),
        .lot_clear_b (lot_clear_b)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // clear pulses per area, counted as they rise
    always @(posedge lot_clear_a or posedge rst) begin
        if (rst) begin
            clear_count_a <= 0;
        end else begin
            clear_count_a <= clear_count_a + 1;
        end
    end

    always @(posedge lot_clear_b or posedge rst) begin
        if (rst) begin
            clear_count_b <= 0;
        end else begin
            clear_count_b <= clear_count_b + 1;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic apply_reset();
        rst     = 1'b1;
        keys    = '0;
        buttons = '0;
        repeat (RESET_CYCLES) next_cycle();
        rst = 1'b0;
    endtask

    // held two cycles, released two
    task automatic press_key(input logic [3:0] key);
        keys      = '0;
        keys[key] = 1'b1;
        repeat (2) next_cycle();
        keys = '0;
        repeat (2) next_cycle();
    endtask

    // first key in the top nibble
    task automatic press_key_list(input logic [3:0] count, input logic [19:0] list);
        logic [19:0] rest;
        rest = list;
        for (int i = 0; i < int'(count); i++) begin
            press_key(rest[19:16]);
            rest = rest << 4;
        end
    endtask

    task automatic press_button(input int idx);
        buttons[idx] = 1'b1;
        repeat (2) next_cycle();
        buttons = '0;
        repeat (2) next_cycle();
    endtask

    function automatic logic [3:0] observed_value(input logic [3:0] op, input logic [3:0] arg);
        logic [3:0] value;
        value = 4'h0;
        case (op)
            OP_FIELD: begin
                case (arg)
                    4'd0:    value = {2'b00, settings.start_a};
                    4'd1:    value = {2'b00, settings.start_b};
                    4'd2:    value = {2'b00, settings.each_a};
                    4'd3:    value = {2'b00, settings.each_b};
                    4'd4:    value = {1'b0, settings.open_a};
                    4'd5:    value = {1'b0, settings.open_b};
                    default: value = settings.discount;
                endcase
            end
            OP_LOGGED_IN: value = {3'b000, logged_in};
            OP_FAILS:     value = {1'b0, fail_count};
            OP_LOCKED:    value = {3'b000, locked};
            default:      value = (arg == 4'd0) ? 4'(clear_count_a) : 4'(clear_count_b);
        endcase
        return value;
    endfunction

    function automatic string value_name(input logic [3:0] op, input logic [3:0] arg);
        string fields [7] = '{"start_a", "start_b", "each_a", "each_b",
                              "open_a", "open_b", "discount"};
        case (op)
            OP_FIELD:     return (arg < 4'd7) ? fields[arg[2:0]] : "discount";
            OP_LOGGED_IN: return "logged_in";
            OP_FAILS:     return "fail_count";
            OP_LOCKED:    return "locked";
            default:      return (arg == 4'd0) ? "lot_clear_a count" : "lot_clear_b count";
        endcase
    endfunction

    task automatic compare(input string name, input logic [3:0] actual,
                           input logic [3:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: got %h, expected %h", name, actual, expected);
            mismatches++;
        end
    endtask

    // outputs may lag the last press by a few cycles
    task automatic expect_value(input logic [3:0] op, input logic [3:0] arg,
                                input logic [3:0] expected);
        int waited;
        waited = 0;
        while (observed_value(op, arg) !== expected && waited < POLL_LIMIT) begin
            next_cycle();
            waited++;
        end
        compare(value_name(op, arg), observed_value(op, arg), expected);
    endtask

    // logged out always leaves the menu at main
    task automatic expect_menu_main();
        int waited;
        waited = 0;
        while (menu_state !== park_admin_pkg::main && waited < POLL_LIMIT) begin
            next_cycle();
            waited++;
        end
        compare("menu_state", {1'b0, menu_state}, {1'b0, park_admin_pkg::main});
    endtask

    initial begin
        int          pc;
        int          gap;
        logic        done;
        logic [31:0] word;
        pc   = 0;
        done = 1'b0;
        void'($urandom(32'h72ed));
        for (int i = 0; i < MAX_OPS; i++) begin
            ops[i] = '0;
        end
        $readmemh("tb/park_admin_tests.txt", ops);
        apply_reset();

        while (!done && pc < MAX_OPS) begin
            word = ops[pc[7:0]];
            case (word[31:28])
                OP_END:    done = 1'b1;
                OP_KEYS:   press_key_list(word[27:24], word[23:4]);
                OP_MID:    press_button(park_admin_pkg::BTN_MID);
                OP_UP:     press_button(park_admin_pkg::BTN_UP);
                OP_RESET:  apply_reset();
                OP_LOGGED_IN: begin
                    expect_value(word[31:28], word[27:24], word[3:0]);
                    if (word[3:0] == 4'h0) begin
                        expect_menu_main();
                    end
                end
                OP_FIELD, OP_FAILS, OP_LOCKED, OP_CLEARS: begin
                    expect_value(word[31:28], word[27:24], word[3:0]);
                end
                default: begin
                    $display("unknown operation code %h in test entry %0d", word[31:28], pc);
                    other_errors++;
                end
            endcase
            gap = int'($urandom % 4);
            repeat (gap) next_cycle();
            pc++;
        end

        if (!done) begin
            $display("the test file has no end operation");
            other_errors++;
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: park_admin.f
hdl/park_admin_pkg.sv
hdl/key_scan.sv
hdl/login_check.sv
hdl/menu_control.sv
hdl/setting_store.sv
hdl/park_admin_top.sv
tb/park_admin_checker.sv
tb/tb_park_admin.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --top-module tb_park_admin \
    -f park_admin.f -o sim_park_admin > sim.log 2>&1 &&
./obj_dir/sim_park_admin >> sim.log 2>&1 ||
echo "test failed" >> sim.log
cat sim.log
! grep -q "test failed" sim.log

// File: tb/park_admin_tests.txt
// hex digits per word: op, arg, five key nibbles, expected value
// op 1 press arg keys, 2 mid, 3 up, 4 field arg, 5 logged_in, 6 fail_count, 7 locked
// op 8 clear count of area arg (0 a, 1 b), 9 reset, 0 end; fields 0 to 6 start_a to discount
// defaults after reset
40000001
41000002
42000001
43000002
44000003
45000003
46000008
50000000
60000000
70000000
// wrong code, then the admin code
15123450
20000000
60000001
50000000
15235680
20000000
50000001
60000000
// prices: start_a 3, start_b 0, each_a rejects 0 then takes 3, each_b 3
122B0000
11300000
20000000
11000000
20000000
11000000
20000000
42000001
11300000
20000000
11300000
20000000
40000003
41000000
42000003
43000003
44000003
45000003
46000008
// open lots 2 and 0, discount rejects 4 then takes 6
12E20000
20000000
11000000
20000000
12D40000
20000000
46000008
11600000
20000000
44000002
45000000
46000006
40000003
// up logs out, later keys change nothing
30000000
50000000
132B3000
20000000
40000003
41000000
60000000
// clear area b, then a cancelled clear of area a
15235680
20000000
50000001
135B2000
20000000
81000001
80000000
145A2000
20000000
80000000
81000001
30000000
// four wrong codes lock the login until reset
15111110
20000000
15111110
20000000
15111110
20000000
60000003
70000000
15111110
20000000
60000004
70000001
15235680
20000000
50000000
60000004
90000000
70000000
60000000
81000000
40000001
15235680
20000000
50000001
00000000
